// ==== blur_core.f ====
verilog/blur_pkg.sv
verilog/row_mem.sv
verilog/line_buffer.sv
verilog/gauss_row_filter.sv
verilog/blur_sequencer.sv
verilog/blur_core.sv
+incdir+tb
tb/blur_core_tb.sv

// ==== Makefile ====
TOP  := blur_core_tb
SRCS := $(filter-out +%,$(shell cat blur_core.f)) tb/blur_model.svh
BIN  := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

$(BIN): blur_core.f $(SRCS)
	verilator --binary --timing --assert -f blur_core.f \
		--top-module $(TOP) -o V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb/blur_model.svh ====
`ifndef BLUR_MODEL_SVH
`define BLUR_MODEL_SVH

// test image kinds
localparam logic [2:0] pat_const  = 3'd0;  // every pixel at one level
localparam logic [2:0] pat_ramp   = 3'd1;  // level grows with column
localparam logic [2:0] pat_dot    = 3'd2;  // one bright pixel on black
localparam logic [2:0] pat_random = 3'd3;  // lcg noise
localparam logic [2:0] pat_full   = 3'd4;  // saturated white

// 32-bit lcg step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// pixel (r, c) of a test image
function automatic blur_pkg::pixel_t pattern_pixel(
    input logic [2:0] kind,
    input logic [7:0] value,               // level, ramp step or dot level
    input int         dot_r,
    input int         dot_c,
    input int         r,
    input int         c,
    input logic [7:0] rnd                  // fresh random byte
);
    case (kind)
        pat_const:  return value;
        pat_ramp:   return 8'(c * int'(value));
        pat_dot:    return ((r == dot_r) && (c == dot_c)) ? value : 8'd0;
        pat_random: return rnd;
        default:    return 8'd255;         // pat_full
    endcase
endfunction

// expected blurred row from the row above, the row itself and the row below
// weights 1 2 1 / 2 4 2 / 1 2 1, outside columns read as zero
function automatic blur_pkg::row_t blur_row_model(
    input blur_pkg::row_t above,
    input blur_pkg::row_t centre,
    input blur_pkg::row_t below
);
    blur_pkg::row_t rows3 [3];
    blur_pkg::row_t result;
    int             sum;
    int             w;
    int             cc;
    rows3[0] = above;
    rows3[1] = centre;
    rows3[2] = below;
    result   = '0;
    for (int c = 0; c < blur_pkg::img_cols; c++) begin
        sum = 0;
        for (int dy = 0; dy < 3; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                cc = c + dx;
                if (cc >= 0 && cc < blur_pkg::img_cols) begin
                    w   = ((dy == 1) ? 2 : 1) * ((dx == 0) ? 2 : 1); // corner 1, edge 2, centre 4
                    sum = sum + w * int'(rows3[dy][cc*blur_pkg::pix_w +: blur_pkg::pix_w]);
                end
            end
        end
        result[c*blur_pkg::pix_w +: blur_pkg::pix_w] = 8'((sum + 8) >> 4); // round, divide by 16
    end
    return result;
endfunction

`endif

// ==== tb/blur_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_core_tb;

    import blur_pkg::*;

    `include "blur_model.svh"

    localparam int          half_period  = 50;     // 100 ns clock
    localparam int          drive_dly    = 5;      // input skew after the edge
    localparam int          reset_cycles = 5;
    localparam int          done_limit   = 64;     // cycles allowed per run
    localparam logic [31:0] lcg_seed     = 32'h44d3;
    localparam int          num_tests    = 7;

    // one table entry, spot is a hand-computed pixel
    typedef struct packed {
        logic [2:0] kind;
        logic [7:0] value;
        logic [3:0] dot_r;
        logic [3:0] dot_c;
        logic       spot;                          // spot fields valid
        logic [3:0] spot_r;
        logic [3:0] spot_c;
        logic [7:0] spot_val;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        done;
    logic        img_we;
    row_addr_t   img_addr_in;
    row_t        img_din;
    row_addr_t   blur_addr_in;
    row_t        blur_dout;

    test_t       tests [num_tests];
    row_t        image [img_rows];                 // current test image
    logic [31:0] rnd_state;                        // lcg state, spans all runs

    blur_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .done         (done),
        .img_we       (img_we),
        .img_addr_in  (img_addr_in),
        .img_din      (img_din),
        .blur_addr_in (blur_addr_in),
        .blur_dout    (blur_dout)
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #drive_dly;                                // inputs move after the edge
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    // kind, value, dot row/col, spot valid, spot row/col, spot value
    task automatic fill_table();
        tests[0] = '{pat_const,  8'd100, 4'd0, 4'd0, 1'b1, 4'd0,  4'd0,  8'd56};  // 9*100 corner
        tests[1] = '{pat_ramp,   8'd16,  4'd0, 4'd0, 1'b1, 4'd5,  4'd5,  8'd80};  // ramp kept
        tests[2] = '{pat_dot,    8'd200, 4'd6, 4'd7, 1'b1, 4'd6,  4'd7,  8'd50};  // 4*200 peak
        tests[3] = '{pat_random, 8'd0,   4'd0, 4'd0, 1'b0, 4'd0,  4'd0,  8'd0};
        tests[4] = '{pat_full,   8'd0,   4'd0, 4'd0, 1'b1, 4'd11, 4'd15, 8'd143}; // 9*255 corner
        tests[5] = '{pat_dot,    8'd255, 4'd0, 4'd0, 1'b1, 4'd0,  4'd0,  8'd64};  // dot in corner
        tests[6] = '{pat_random, 8'd0,   4'd0, 4'd0, 1'b0, 4'd0,  4'd0,  8'd0};   // new noise
    endtask

    task automatic build_image(input test_t t);
        for (int r = 0; r < img_rows; r++) begin
            for (int c = 0; c < img_cols; c++) begin
                rnd_state = lcg_next(rnd_state);
                image[r][c*pix_w +: pix_w] = pattern_pixel(t.kind, t.value, int'(t.dot_r),
                                                           int'(t.dot_c), r, c, rnd_state[23:16]);
            end
        end
    endtask

    // zero rows above and below the image
    function automatic row_t image_row(input int r);
        if (r < 0 || r >= img_rows) begin
            return '0;
        end
        return image[r];
    endfunction

    task automatic load_image();
        for (int r = 0; r < img_rows; r++) begin
            img_we      = 1'b1;
            img_addr_in = row_addr_t'(r);
            img_din     = image[r];
            next_cycle();
        end
        img_we = 1'b0;
    endtask

    task automatic start_run();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        assert (done === 1'b0) else begin      // done must drop once start is taken
            $display("error: t=%0t done got %b expected 0", $time, done);
            abort_run();
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < done_limit) begin
            next_cycle();
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("timeout: done did not rise within %0d cycles after start", done_limit);
            abort_run();
        end
    endtask

    task automatic check_rows(input test_t t);
        row_t       exp;
        logic [7:0] got_pix;
        for (int r = 0; r < img_rows; r++) begin
            blur_addr_in = row_addr_t'(r);
            next_cycle();                          // one cycle read latency
            exp = blur_row_model(image_row(r - 1), image_row(r), image_row(r + 1));
            assert (blur_dout === exp) else begin
                $display("error: t=%0t blur_dout row %0d got %h expected %h",
                         $time, r, blur_dout, exp);
                abort_run();
            end
            if (t.spot && int'(t.spot_r) == r) begin
                got_pix = blur_dout[int'(t.spot_c)*pix_w +: pix_w];
                assert (got_pix === t.spot_val) else begin
                    $display("error: t=%0t blur_dout row %0d pixel %0d got %0d expected %0d",
                             $time, r, t.spot_c, got_pix, t.spot_val);
                    abort_run();
                end
            end
        end
        assert (done === 1'b1) else begin      // level holds through readback
            $display("error: t=%0t done got %b expected 1", $time, done);
            abort_run();
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        img_we       = 1'b0;
        img_addr_in  = '0;
        img_din      = '0;
        blur_addr_in = '0;
        rnd_state    = lcg_seed;
        fill_table();

        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;

        // no start yet, done stays low
        for (int i = 0; i < 4; i++) begin
            assert (done === 1'b0) else begin
                $display("error: t=%0t done got %b expected 0", $time, done);
                abort_run();
            end
            next_cycle();
        end

        // back to back runs, no reset in between
        for (int t = 0; t < num_tests; t++) begin
            build_image(tests[t]);
            load_image();
            start_run();
            wait_done();
            check_rows(tests[t]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/blur_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_core (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,        // begin a blur run
    output logic                     done,         // blurred image ready
    input  wire                      img_we,       // host row write
    input  wire blur_pkg::row_addr_t img_addr_in,  // host image row
    input  wire blur_pkg::row_t      img_din,      // host row data
    input  wire blur_pkg::row_addr_t blur_addr_in, // host readback row
    output blur_pkg::row_t           blur_dout     // blurred row, one cycle later
);

    import blur_pkg::*;

    logic      busy;                               // sequencer running
    logic      img_we_ok;                          // host write while idle
    row_addr_t seq_rd_addr;                        // sequencer image read
    row_addr_t img_raddr;                          // muxed image read
    row_t      img_dout;                           // image row out
    logic      lb_shift;
    logic      lb_zero_fill;
    row_t      row_top;
    row_t      row_mid;
    row_t      row_bot;
    row_t      blur_row;                           // filter result
    logic      blur_we;
    row_addr_t blur_waddr;

    // host owns the image memory outside a run
    assign img_we_ok = img_we && !busy;            // writes during a run dropped
    assign img_raddr = busy ? seq_rd_addr : img_addr_in;

    row_mem img_mem (
        .clk   (clk),
        .we    (img_we_ok),
        .waddr (img_addr_in),
        .wdata (img_din),
        .raddr (img_raddr),
        .rdata (img_dout)
    );

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (lb_shift),
        .zero_fill (lb_zero_fill),
        .row_in    (img_dout),
        .row_top   (row_top),
        .row_mid   (row_mid),
        .row_bot   (row_bot)
    );

    gauss_row_filter u_gauss_row_filter (
        .clk     (clk),
        .row_top (row_top),
        .row_mid (row_mid),
        .row_bot (row_bot),
        .row_out (blur_row)
    );

    blur_sequencer u_blur_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rd_addr    (seq_rd_addr),
        .shift      (lb_shift),
        .zero_fill  (lb_zero_fill),
        .blur_we    (blur_we),
        .blur_waddr (blur_waddr),
        .busy       (busy),
        .done       (done)
    );

    // sequencer writes, host reads
    row_mem blur_mem (
        .clk   (clk),
        .we    (blur_we),
        .waddr (blur_waddr),
        .wdata (blur_row),
        .raddr (blur_addr_in),
        .rdata (blur_dout)
    );

endmodule

`default_nettype wire

// ==== verilog/blur_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_sequencer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,      // one-cycle request
    output blur_pkg::row_addr_t      rd_addr,    // image read row
    output logic                     shift,      // line buffer advance
    output logic                     zero_fill,  // border row select
    output logic                     blur_we,    // blurred row write
    output blur_pkg::row_addr_t      blur_waddr, // blurred row index
    output logic                     busy,       // run in progress
    output logic                     done        // level, until next start
);

    import blur_pkg::*;

    seq_state_t           state;
    seq_state_t           state_nxt;
    logic [addr_w:0]      step;                  // cycle count within a run
    logic                 active;                // prime, run or flush
    logic                 accept;                // start taken this cycle

    // step timeline, rows read at step r, shifted at r+1, written at r+4
    //   0      read row 0, shift top zero row
    //   1..12  shift rows 0..11
    //   13     shift bottom zero row
    //   4..15  write blurred rows 0..11
    assign active = (state == st_prime) || (state == st_run) || (state == st_flush);
    assign busy   = active;
    assign done   = (state == st_done);
    assign accept = start && !active;            // idle or done only

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (accept) state_nxt = st_prime;
            st_prime: if (int'(step) == 2) state_nxt = st_run;          // rows 0, 1 in
            st_run:   if (int'(step) == img_rows) state_nxt = st_flush; // last row in
            st_flush: if (int'(step) == img_rows + 3) state_nxt = st_done;
            st_done:  if (accept) state_nxt = st_prime; // rerun without reset
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
        end else if (accept) begin
            step <= '0;                          // new run
        end else if (active) begin
            step <= step + 1'b1;                 // free running, no stalls
        end
    end

    // read address tracks step, beyond the last row the data is ignored
    assign rd_addr = step[addr_w-1:0];

    always_comb begin
        shift     = active && (int'(step) <= img_rows + 1);
        zero_fill = shift && ((step == '0) || (int'(step) == img_rows + 1));
    end

    // filter result lands two cycles after the shift that completes it
    assign blur_we    = active && (int'(step) >= 4);
    assign blur_waddr = row_addr_t'(step - 3'd4);

endmodule

`default_nettype wire

// ==== verilog/gauss_row_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module gauss_row_filter (
    input  wire                 clk,
    input  wire blur_pkg::row_t row_top,    // row above, y-1
    input  wire blur_pkg::row_t row_mid,    // centre row, y
    input  wire blur_pkg::row_t row_bot,    // row below, y+1
    output blur_pkg::row_t      row_out     // registered blurred row
);

    import blur_pkg::*;

    // pixel x of a row widened for the sum, zero outside the row
    function automatic logic [acc_w-1:0] tap(input row_t row, input int x);
        logic [row_w+2*pix_w-1:0] padded;   // one blank pixel at each end
        padded = {pixel_t'(0), row, pixel_t'(0)};
        return acc_w'(padded[(x+1)*pix_w +: pix_w]);
    endfunction

    // all columns in parallel, result one cycle after the rows
    always_ff @(posedge clk) begin
        for (int c = 0; c < img_cols; c++) begin
            row_out[c*pix_w +: pix_w] <= pixel_t'((
                  k_corner * (tap(row_top, c - 1) + tap(row_top, c + 1)
                            + tap(row_bot, c - 1) + tap(row_bot, c + 1))
                + k_edge   * (tap(row_top, c) + tap(row_bot, c)
                            + tap(row_mid, c - 1) + tap(row_mid, c + 1))
                + k_center * tap(row_mid, c)
                + k_round) >> k_shift);     // round, divide by 16
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 shift,      // advance one row
    input  wire                 zero_fill,  // push a border row instead of row_in
    input  wire blur_pkg::row_t row_in,     // from image memory
    output blur_pkg::row_t      row_top,    // oldest row, y-1
    output blur_pkg::row_t      row_mid,    // centre row, y
    output blur_pkg::row_t      row_bot     // newest row, y+1
);

    import blur_pkg::*;

    row_t next_row;                         // what enters at the bottom

    assign next_row = zero_fill ? '0 : row_in; // top / bottom image border

    // three-deep shift register, rows move upward
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_top <= '0;
            row_mid <= '0;
            row_bot <= '0;
        end else if (shift) begin
            row_top <= row_mid;             // drop oldest
            row_mid <= row_bot;
            row_bot <= next_row;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/row_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_mem (
    input  wire                   clk,
    input  wire                   we,       // write strobe
    input  wire blur_pkg::row_addr_t waddr, // write row
    input  wire blur_pkg::row_t   wdata,    // whole row in
    input  wire blur_pkg::row_addr_t raddr, // read row
    output blur_pkg::row_t        rdata     // registered, one cycle latency
);

    import blur_pkg::*;

    row_t mem [img_rows];                   // one word per image row

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;            // write port
        end
    end

    // synchronous read, old data on same-address collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== verilog/blur_pkg.sv ====
`default_nettype none

package blur_pkg;

    // image geometry
    localparam int img_cols = 16;               // pixels per row
    localparam int img_rows = 12;               // rows per image
    localparam int pix_w    = 8;                // grayscale depth
    localparam int row_w    = pix_w * img_cols; // one memory word = one row
    localparam int addr_w   = 4;                // row address bits

    typedef logic [pix_w-1:0]  pixel_t;         // single pixel
    typedef logic [row_w-1:0]  row_t;           // pixel 0 in the low byte
    typedef logic [addr_w-1:0] row_addr_t;      // row index

    // 3x3 gaussian, 1-2-1 outer product, sum of weights 16
    localparam int acc_w = 12;                  // 16*255 + 8 fits in 12 bits

    localparam logic [acc_w-1:0] k_corner = 12'd1; // diagonal neighbours
    localparam logic [acc_w-1:0] k_edge   = 12'd2; // n, s, e, w neighbours
    localparam logic [acc_w-1:0] k_center = 12'd4; // pixel itself
    localparam logic [acc_w-1:0] k_round  = 12'd8; // half lsb before shift
    localparam int               k_shift  = 4;     // divide by 16

    // sequencer states
    // prime fills the line buffer, run streams rows and writes results,
    // flush pushes the bottom border row and drains the last writes
    typedef enum logic [2:0] {
        st_idle,
        st_prime,
        st_run,
        st_flush,
        st_done
    } seq_state_t;

endpackage

`default_nettype wire
